//--- tb.f
+incdir+verilog
verilog/xbar_pkg.sv
verilog/xbar_regs.sv
verilog/xbar_shifter.sv
verilog/xbar_control.sv
verilog/xbar_bank.sv
test/tb_xbar.sv

//--- test/tb_xbar.sv
`include "xbar_macros.svh"

module tb_xbar;
  import xbar_pkg::*;

  localparam int STREAM_BITS = `XBAR_WORDS * `XBAR_WORD_BITS;  // 512 bits per transfer

  typedef logic [STREAM_BITS-1:0] stream_t;  // first bit on the wire sits at the msb

  logic                                 sclk;
  logic                                 reset;
  cmd_bus_t                             bus;
  logic [15:0]                          data_out;
  xbar_pins_t [`XBAR_NUM-1:0]           pins;

  logic [`XBAR_WORD_BITS-1:0] saved [`XBAR_NUM][`XBAR_WORDS];  // words last written
  stream_t                    cap_bits [`XBAR_NUM];
  int                         cap_count [`XBAR_NUM];           // valid bits seen
  int                         latch_count [`XBAR_NUM];         // pclk low cycles seen
  int                         idle_miss [`XBAR_NUM];           // cycles with pins off idle
  int                         value_errs;
  int                         other_errs;
  logic [31:0]                lcg_state = 32'h5182_9b6f;
  logic [15:0]                rd;

  xbar_bank u_dut (
    .sclk     (sclk),
    .reset    (reset),
    .bus      (bus),
    .data_out (data_out),
    .pins     (pins)
  );

  always #10 sclk = ~sclk;  // 20 unit period

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes constants
    return lcg_state;
  endfunction

  function automatic logic [7:0] position(input int k);
    return 8'(`XBAR_BASE_POS + k);
  endfunction

  function automatic xbar_pins_t idle_pins();
    xbar_pins_t p;
    p.xbar_clock = 1'b0;
    p.pclk       = 1'b1;  // latch is active low
    p.sin        = 1'b0;
    return p;
  endfunction

  // expected wire order is word 0 first and each word msb first
  function automatic stream_t model_stream(input int ctrl);
    stream_t s;
    s = '0;
    for (int w = 0; w < `XBAR_WORDS; w++) begin
      for (int b = `XBAR_WORD_BITS - 1; b >= 0; b--) begin
        s = {s[STREAM_BITS-2:0], saved[ctrl][w][b]};
      end
    end
    return s;
  endfunction

  function automatic string seq_state(input int k);
    shift_state_e st;
    st = (k == 0) ? u_dut.g_ctrl[0].u_ctrl.u_shifter.state
                  : u_dut.g_ctrl[1].u_ctrl.u_shifter.state;
    return st.name();
  endfunction

  // --------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------
  task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s read %h, expected %h", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_pins(input int ctrl, input xbar_pins_t got, input xbar_pins_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: controller %0d pins %b, expected %b", $time, ctrl, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_stream(input int ctrl, input stream_t got, input int got_n,
                              input stream_t exp);
    int first;
    first = -1;
    if (got_n != STREAM_BITS) begin
      $display("** Error at %0t: controller %0d sent %0d valid bits, expected %0d",
               $time, ctrl, got_n, STREAM_BITS);
      value_errs++;
    end else if (got !== exp) begin
      for (int i = STREAM_BITS - 1; i >= 0; i--) begin
        if (first < 0 && got[i] !== exp[i]) begin
          first = STREAM_BITS - 1 - i;  // wire order
        end
      end
      $display("** Error at %0t: controller %0d stream differs first at word %0d bit %0d",
               $time, ctrl, first / 32, 31 - (first % 32));
      value_errs++;
    end
  endtask

  // --------------------------------------------------------------------
  // capture and compare per controller
  // --------------------------------------------------------------------
  for (genvar k = 0; k < `XBAR_NUM; k++) begin : g_mon
    event latched;

    always @(posedge sclk) begin
      if (!reset) begin
        if (pins[k].xbar_clock === 1'b1) begin
          cap_bits[k]  = {cap_bits[k][STREAM_BITS-2:0], pins[k].sin};  // bit taken here
          cap_count[k] = cap_count[k] + 1;
        end
        if (pins[k].pclk === 1'b0) begin
          latch_count[k] = latch_count[k] + 1;
          -> latched;
        end
        if (pins[k] !== idle_pins()) begin
          idle_miss[k] = idle_miss[k] + 1;  // any pin away from its rest level
        end
      end
    end

    // stream is complete once the latch shows
    always @(latched) begin
      check_stream(k, cap_bits[k], cap_count[k], model_stream(k));
    end
  end

  // --------------------------------------------------------------------
  // bus and wait tasks
  // --------------------------------------------------------------------
  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
    @(negedge sclk);
    bus.enable = 1'b1;
    bus.wr     = 1'b1;
    bus.re     = 1'b0;
    bus.addr   = addr;
    bus.data   = data;
    @(negedge sclk);
    bus        = '0;  // lands on the edge in between
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
    @(negedge sclk);
    bus.enable = 1'b1;
    bus.wr     = 1'b0;
    bus.re     = 1'b1;
    bus.addr   = addr;
    bus.data   = '0;
    @(negedge sclk);
    data       = data_out;  // registered data shows one cycle later
    bus        = '0;
  endtask

  task automatic load_words(input int k);
    for (int w = 0; w < `XBAR_WORDS; w++) begin
      saved[k][w] = next_rand();
      bus_write({position(k), 8'h10 + 8'(w)}, saved[k][w]);  // addr[3:0] picks the word
    end
  endtask

  task automatic clear_capture();
    for (int k = 0; k < `XBAR_NUM; k++) begin
      cap_bits[k]    = '0;
      cap_count[k]   = 0;
      latch_count[k] = 0;
      idle_miss[k]   = 0;
    end
  endtask

  task automatic wait_latch(input int k);
    int cycles;
    cycles = 0;
    while (latch_count[k] == 0 && cycles < 2000) begin
      @(negedge sclk);
      cycles++;
    end
    if (latch_count[k] == 0) begin
      $display("timeout: controller %0d never pulsed its latch, sequencer in %s",
               k, seq_state(k));
      other_errs++;
    end
  endtask

  task automatic wait_busy_low(input int k);
    logic [15:0] val;
    int          tries;
    val   = 16'd1;
    tries = 0;
    while (val !== 16'd0 && tries < 1000) begin
      bus_read({position(k), REG_BUSY}, val);
      tries++;
    end
    if (val !== 16'd0) begin
      $display("timeout: busy at position %0d never fell", k);
      other_errs++;
    end
  endtask

  // --------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------
  initial begin
    sclk       = 1'b0;
    reset      = 1'b1;
    bus        = '0;
    value_errs = 0;
    other_errs = 0;
    clear_capture();
    repeat (10) @(negedge sclk);
    reset = 1'b0;
    @(negedge sclk);

    // idle pins and busy after reset
    for (int k = 0; k < `XBAR_NUM; k++) begin
      check_pins(k, pins[k], idle_pins());
      bus_read({position(k), REG_BUSY}, rd);
      check_word("busy after reset", rd, 16'd0);
    end

    // id readback plus zero reads at an unmapped position and offset
    for (int k = 0; k < `XBAR_NUM; k++) begin
      bus_read({position(k), REG_ID}, rd);
      check_word("id", rd, `XBAR_ID);
    end
    bus_read({8'h02, REG_ID}, rd);
    check_word("id at position 2", rd, 16'd0);
    bus_read({position(0), 8'h05}, rd);
    check_word("unmapped offset", rd, 16'd0);

    // single transfer on controller 0 with a second command that gets dropped
    load_words(0);
    clear_capture();
    bus_write({position(0), REG_CMD}, next_rand() | 32'd1);
    bus_read({position(0), REG_BUSY}, rd);
    check_word("busy during transfer", rd, 16'd1);
    bus_write({position(0), REG_CMD}, 32'h1);  // must not start another transfer
    wait_latch(0);
    repeat (600) @(negedge sclk);               // room for a stray second transfer
    check_count("controller 0 valid bits", cap_count[0], STREAM_BITS);
    check_count("controller 0 latch pulses", latch_count[0], 1);
    check_count("controller 1 valid bits", cap_count[1], 0);
    check_count("controller 1 latch pulses", latch_count[1], 0);
    check_count("controller 1 cycles off idle", idle_miss[1], 0);
    wait_busy_low(0);
    bus_read({position(0), REG_BUSY}, rd);
    check_word("busy after latch", rd, 16'd0);

    // both controllers at once with their own words
    load_words(0);
    load_words(1);
    clear_capture();
    bus_write({position(0), REG_CMD}, 32'h1);
    bus_write({position(1), REG_CMD}, 32'h8000_0000);
    wait_latch(0);
    wait_latch(1);
    repeat (4) @(negedge sclk);
    for (int k = 0; k < `XBAR_NUM; k++) begin
      check_count($sformatf("controller %0d latch pulses", k), latch_count[k], 1);
    end

    // zero command starts nothing
    clear_capture();
    bus_write({position(0), REG_CMD}, 32'h0);
    bus_write({position(1), REG_CMD}, 32'h0);
    repeat (600) @(negedge sclk);
    for (int k = 0; k < `XBAR_NUM; k++) begin
      check_count($sformatf("controller %0d bits after zero command", k), cap_count[k], 0);
    end

    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/xbar_bank.sv
`include "xbar_macros.svh"

module xbar_bank (
  input  logic                                 sclk,
  input  logic                                 reset,
  input  xbar_pkg::cmd_bus_t                   bus,      // shared by all controllers
  output logic [15:0]                          data_out,
  output xbar_pkg::xbar_pins_t [`XBAR_NUM-1:0] pins
);

  logic [15:0] rd_data [`XBAR_NUM];  // per controller readback

  //----------------------------------------------------------------------
  // one controller per bus position
  //----------------------------------------------------------------------
  for (genvar k = 0; k < `XBAR_NUM; k++) begin : g_ctrl
    xbar_control #(
      .POSITION (8'(`XBAR_BASE_POS + k))  // consecutive positions
    ) u_ctrl (
      .sclk     (sclk),
      .reset    (reset),
      .bus      (bus),
      .data_out (rd_data[k]),
      .pins     (pins[k])
    );
  end

  // only the addressed controller returns nonzero
  always_comb begin
    data_out = '0;
    for (int i = 0; i < `XBAR_NUM; i++) begin
      data_out = data_out | rd_data[i];
    end
  end

endmodule

//--- verilog/xbar_control.sv
`include "xbar_macros.svh"

module xbar_control #(
  parameter logic [7:0] POSITION = 8'h00  // bus position of this crossbar
) (
  input  logic                 sclk,
  input  logic                 reset,
  input  xbar_pkg::cmd_bus_t   bus,
  output logic [15:0]          data_out,
  output xbar_pkg::xbar_pins_t pins
);

  logic                       start;
  logic [`XBAR_WORD_BITS-1:0] word;
  logic [3:0]                 word_sel;
  logic                       busy;
  logic                       done;

  // bus side, word bank and command
  xbar_regs #(
    .POSITION (POSITION)
  ) u_regs (
    .sclk     (sclk),
    .reset    (reset),
    .bus      (bus),
    .word_sel (word_sel),
    .busy     (busy),
    .done     (done),
    .start    (start),
    .word     (word),
    .data_out (data_out)
  );

  // crossbar side, serial transfer
  xbar_shifter u_shifter (
    .sclk     (sclk),
    .reset    (reset),
    .start    (start),
    .word     (word),
    .word_sel (word_sel),
    .busy     (busy),
    .done     (done),
    .pins     (pins)
  );

endmodule

//--- verilog/xbar_macros.svh
`ifndef XBAR_MACROS_SVH
`define XBAR_MACROS_SVH

// configuration store of one crossbar
`define XBAR_WORDS      16          // words per crossbar
`define XBAR_WORD_BITS  32          // bits per word, 512 bits in all

// readback constant
`define XBAR_ID         16'h7ba2    // reads a bit like "xbar"

// bank layout on the command bus
`define XBAR_NUM        2           // controllers in the bank
`define XBAR_BASE_POS   8'h00       // addr[15:8] of controller 0

`endif

//--- verilog/xbar_pkg.sv
`include "xbar_macros.svh"

package xbar_pkg;

  // command bus as seen by every controller
  typedef struct packed {
    logic                       enable;  // cycle valid
    logic                       wr;      // write strobe
    logic                       re;      // read strobe
    logic [15:0]                addr;    // [15:8] position, [7:0] offset
    logic [`XBAR_WORD_BITS-1:0] data;    // write data
  } cmd_bus_t;

  // pins facing one crossbar
  typedef struct packed {
    logic xbar_clock;  // bit valid, high while sin carries a bit
    logic pclk;        // latch, one low pulse sets the switches
    logic sin;         // serial data, msb first
  } xbar_pins_t;

  // register offsets in addr[7:0]
  typedef enum logic [7:0] {
    REG_ID   = 8'h09,
    REG_BUSY = 8'h0A,
    REG_CMD  = 8'h20
  } reg_off_e;

  // transfer sequencer states
  typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_LOAD, S_LATCH} shift_state_e;

endpackage

//--- verilog/xbar_regs.sv
`include "xbar_macros.svh"

module xbar_regs #(
  parameter logic [7:0] POSITION = 8'h00  // bus position, compared with addr[15:8]
) (
  input  logic                       sclk,
  input  logic                       reset,
  input  xbar_pkg::cmd_bus_t         bus,
  input  logic [3:0]                 word_sel,  // word the sequencer wants next
  input  logic                       busy,
  input  logic                       done,
  output logic                       start,     // level, command pending
  output logic [`XBAR_WORD_BITS-1:0] word,
  output logic [15:0]                data_out
);
  import xbar_pkg::*;

  logic                       sel;       // this controller addressed
  reg_off_e                   offset;    // register offset of the cycle
  logic                       wr_cmd;
  logic                       wr_cfg;
  logic [`XBAR_WORD_BITS-1:0] command;   // nonzero starts a transfer
  logic [`XBAR_WORD_BITS-1:0] cfg_words [`XBAR_WORDS];

  //----------------------------------------------------------------------
  // address decode
  //----------------------------------------------------------------------
  assign sel    = bus.enable && (bus.addr[15:8] == POSITION);
  assign offset = reg_off_e'(bus.addr[7:0]);

  assign wr_cmd = sel && bus.wr && (offset == REG_CMD);
  // every other offset lands in the word bank, addr[3:0] picks the word
  assign wr_cfg = sel && bus.wr && (offset != REG_CMD);

  //----------------------------------------------------------------------
  // configuration word bank
  //----------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      for (int i = 0; i < `XBAR_WORDS; i++) begin
        cfg_words[i] <= '0;                  // crossbar opens all switches
      end
    end else if (wr_cfg) begin
      cfg_words[bus.addr[3:0]] <= bus.data;  // lands at once, even mid transfer
    end
  end

  // async read port for the sequencer
  assign word = cfg_words[word_sel];

  //----------------------------------------------------------------------
  // command register
  //----------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      command <= '0;
    end else if (done || busy) begin
      command <= '0;           // held at zero for the whole transfer
    end else if (wr_cmd) begin
      command <= bus.data;     // zero here is a no-op
    end
  end

  assign start = (command != '0);

  // registered readback, valid the cycle after the read strobe
  always_ff @(posedge sclk) begin
    if (reset) begin
      data_out <= '0;
    end else if (sel && bus.re) begin
      case (offset)
        REG_ID:   data_out <= `XBAR_ID;
        REG_BUSY: data_out <= {15'd0, busy};  // flag in bit 0
        default:  data_out <= '0;             // words are write only
      endcase
    end else begin
      data_out <= '0;          // idle cycles keep the bank OR clean
    end
  end

endmodule

//--- verilog/xbar_shifter.sv
`include "xbar_macros.svh"

module xbar_shifter (
  input  logic                       sclk,
  input  logic                       reset,
  input  logic                       start,
  input  logic [`XBAR_WORD_BITS-1:0] word,
  output logic [3:0]                 word_sel,
  output logic                       busy,
  output logic                       done,      // one cycle, on the last bit
  output xbar_pkg::xbar_pins_t       pins
);
  import xbar_pkg::*;

  // index of the final bit of the 512 bit stream
  localparam logic [8:0] LAST_BIT = 9'(`XBAR_WORDS * `XBAR_WORD_BITS - 1);

  shift_state_e               state;
  shift_state_e               next_state;
  logic [8:0]                 bit_cnt;    // bits sent so far
  logic [`XBAR_WORD_BITS-1:0] shreg;      // msb drives sin
  logic                       cnt_clr;
  logic                       cnt_up;
  logic                       load;
  logic                       shift;

  //----------------------------------------------------------------------
  // FSM
  //----------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    cnt_clr    = 1'b0;
    cnt_up     = 1'b0;
    load       = 1'b0;
    shift      = 1'b0;
    done       = 1'b0;
    busy       = 1'b1;                   // only idle is not busy
    case (state)
      S_IDLE: begin
        busy    = 1'b0;
        cnt_clr = 1'b1;                  // word_sel stays on word 0
        if (start) begin
          load       = 1'b1;             // word 0 goes in now
          next_state = S_SHIFT;
        end
      end
      S_SHIFT: begin
        shift  = 1'b1;                   // bit on sin is taken this cycle
        cnt_up = 1'b1;
        if (bit_cnt == LAST_BIT) begin
          done       = 1'b1;             // clears the command register
          next_state = S_LATCH;
        end else if (bit_cnt[4:0] == 5'h1f) begin
          next_state = S_LOAD;           // word boundary
        end
      end
      S_LOAD: begin
        load       = 1'b1;               // counter already points at next word
        next_state = S_SHIFT;
      end
      S_LATCH: begin
        cnt_clr    = 1'b1;
        next_state = S_IDLE;
      end
      default: next_state = S_IDLE;
    endcase
  end

  //----------------------------------------------------------------------
  // bit counter and output shift register
  //----------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      bit_cnt <= '0;
      shreg   <= '0;                     // keeps sin low out of reset
    end else begin
      if (cnt_clr) begin
        bit_cnt <= '0;
      end else if (cnt_up) begin
        bit_cnt <= bit_cnt + 9'd1;
      end
      if (load) begin
        shreg <= word;
      end else if (shift) begin
        shreg <= {shreg[`XBAR_WORD_BITS-2:0], 1'b0};  // zeros fill behind
      end
    end
  end

  assign word_sel        = bit_cnt[8:5];        // 32 bits per word
  assign pins.xbar_clock = (state == S_SHIFT);
  assign pins.pclk       = (state != S_LATCH);  // active low latch
  assign pins.sin        = shreg[`XBAR_WORD_BITS-1];

endmodule
